// File: source/pkt_defines.svh
////////////////////////////////////////
// packet loopback build constants
// beat width, length limit, LFSR taps
////////////////////////////////////////

`ifndef PKT_DEFINES_SVH
`define PKT_DEFINES_SVH

// bytes carried by one stream beat
`define PKT_DATA_BYTES 8

// largest payload length in bytes, zero is never sent
`define PKT_MAX_BLEN 255

// galois taps for x^64 + x^63 + x^61 + x^60 + 1
`define PKT_LFSR_POLY 64'hD800_0000_0000_0000

`endif

// File: source/pkt_stream_pkg.sv
////////////////////////////////////////
// stream types for the packet loopback
// request, beat descriptor, beat, LFSR
////////////////////////////////////////

`include "pkt_defines.svh"

package pkt_stream_pkg;

    localparam int DATA_W      = `PKT_DATA_BYTES * 8;
    localparam int LEN_W       = $clog2(`PKT_MAX_BLEN + 1);
    localparam int BYTE_IDX_W  = $clog2(`PKT_DATA_BYTES);
    // header beat plus payload beats of the longest packet
    localparam int MAX_BEATS   = (`PKT_MAX_BLEN + `PKT_DATA_BYTES - 1) / `PKT_DATA_BYTES + 1;
    localparam int BEAT_CNT_W  = $clog2(MAX_BEATS + 1);

    // request as latched on accept
    typedef struct packed {
        logic [31:0]      seed;
        logic [LEN_W-1:0] byte_len;
        logic             corrupt;
    } pkt_req_t;

    // one descriptor per beat, stage 1 to stage 2
    typedef struct packed {
        logic                       first;
        logic                       last;
        logic [`PKT_DATA_BYTES-1:0] keep;
        pkt_req_t                   req;
    } beat_desc_t;

    typedef struct packed {
        logic [DATA_W-1:0]          data;
        logic [`PKT_DATA_BYTES-1:0] keep;
        logic                       first;
        logic                       last;
    } beat_t;

    // one galois step, shift right and fold taps on a set lsb
    function automatic logic [DATA_W-1:0] lfsr_next(input logic [DATA_W-1:0] state);
        lfsr_next = state >> 1;
        if (state[0]) begin
            lfsr_next = lfsr_next ^ `PKT_LFSR_POLY;
        end
    endfunction

    // byte enables widened to a bit mask
    function automatic logic [DATA_W-1:0] keep_to_mask(input logic [`PKT_DATA_BYTES-1:0] keep);
        keep_to_mask = '0;
        for (int i = 0; i < `PKT_DATA_BYTES; i++) begin
            keep_to_mask[i*8 +: 8] = {8{keep[i]}};
        end
    endfunction

endpackage

// File: source/pkt_check_pkg.sv
////////////////////////////////////////
// checker result types
////////////////////////////////////////

package pkt_check_pkg;

    // bad byte count saturates at all ones
    localparam int BAD_CNT_W = 4;

    // one per packet, pulsed after the last beat
    typedef struct packed {
        logic [31:0]                      seed;
        logic [pkt_stream_pkg::LEN_W-1:0] byte_len;
        // some kept byte differed from the regenerated payload
        logic                             data_error;
        // payload beat count disagrees with header length
        logic                             length_error;
        logic [BAD_CNT_W-1:0]             bad_bytes;
    } pkt_result_t;

endpackage

// File: source/pkt_beat_sequencer.sv
////////////////////////////////////////
// stage 1, request to beat descriptors
////////////////////////////////////////

`timescale 1ns/10ps

`include "pkt_defines.svh"

module pkt_beat_sequencer (
    input  logic                       clk_ifc,
    input  logic                       rst,
    input  logic                       send_req,
    input  logic [31:0]                seed,
    input  logic [7:0]                 byte_len,
    input  logic                       corrupt,
    output logic                       busy,
    output pkt_stream_pkg::beat_desc_t desc,
    output logic                       desc_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_RUN
    } seq_state_t;

    seq_state_t                                state;
    logic                                      accept;
    pkt_stream_pkg::pkt_req_t                  req;
    logic [pkt_stream_pkg::BEAT_CNT_W-1:0]     pay_beats;
    logic [pkt_stream_pkg::BEAT_CNT_W-1:0]     beat_idx;
    logic [`PKT_DATA_BYTES-1:0]                last_keep;
    logic [pkt_stream_pkg::LEN_W:0]            len_round;
    logic [pkt_stream_pkg::BYTE_IDX_W-1:0]     len_rem;

    // zero length never starts a packet
    assign accept    = (state == ST_IDLE) && send_req && !busy && (byte_len != '0);
    assign len_round = {1'b0, req.byte_len} + (pkt_stream_pkg::LEN_W + 1)'(`PKT_DATA_BYTES - 1);
    assign len_rem   = req.byte_len[pkt_stream_pkg::BYTE_IDX_W-1:0];

    ////////////////////////////////////////
    // control
    always_ff @(posedge clk_ifc) begin
        if (rst) begin
            state      <= ST_IDLE;
            busy       <= 1'b0;
            desc_valid <= 1'b0;
            beat_idx   <= '0;
        end else begin
            desc_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // busy drops one cycle after the last descriptor
                    if (accept) begin
                        busy  <= 1'b1;
                        state <= ST_SETUP;
                    end else begin
                        busy <= 1'b0;
                    end
                end
                ST_SETUP: begin
                    beat_idx <= '0;
                    state    <= ST_RUN;
                end
                ST_RUN: begin
                    desc_valid <= 1'b1;
                    beat_idx   <= beat_idx + 1'b1;
                    if (beat_idx == pay_beats) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // request latch and descriptor fields
    always_ff @(posedge clk_ifc) begin
        if (accept) begin
            req <= '{seed, byte_len, corrupt};
        end
        // beat count and tail mask, one cycle after accept
        if (state == ST_SETUP) begin
            pay_beats <= pkt_stream_pkg::BEAT_CNT_W'(len_round >> pkt_stream_pkg::BYTE_IDX_W);
            if (len_rem == '0) begin
                last_keep <= '1;
            end else begin
                last_keep <= ~({`PKT_DATA_BYTES{1'b1}} << len_rem);
            end
        end
        // index 0 is the header, payload runs 1..pay_beats
        if (state == ST_RUN) begin
            desc.first <= (beat_idx == '0);
            desc.last  <= (beat_idx == pay_beats);
            desc.keep  <= (beat_idx == pay_beats) ? last_keep : '1;
            desc.req   <= req;
        end
    end

endmodule

// File: source/pkt_payload_gen.sv
////////////////////////////////////////
// stage 2, descriptors to data beats
// header, LFSR payload, optional flip
////////////////////////////////////////

`timescale 1ns/10ps

`include "pkt_defines.svh"

module pkt_payload_gen (
    input  logic                       clk_ifc,
    input  logic                       rst,
    input  pkt_stream_pkg::beat_desc_t desc,
    input  logic                       desc_valid,
    output pkt_stream_pkg::beat_t      beat,
    output logic                       beat_valid
);

    logic [pkt_stream_pkg::DATA_W-1:0] lfsr;
    logic [pkt_stream_pkg::DATA_W-1:0] lfsr_step;
    logic [pkt_stream_pkg::DATA_W-1:0] hdr_data;
    logic [pkt_stream_pkg::DATA_W-1:0] pay_data;
    // next payload beat is the first one of its packet
    logic                              pay_first;

    always_comb begin
        lfsr_step = pkt_stream_pkg::lfsr_next(lfsr);
        // seed low word, length above, rest zero
        hdr_data        = '0;
        hdr_data[31:0]  = desc.req.seed;
        hdr_data[39:32] = desc.req.byte_len;
        // bytes past keep are zero
        pay_data = lfsr_step & pkt_stream_pkg::keep_to_mask(desc.keep);
        if (desc.req.corrupt && pay_first) begin
            pay_data[0] = ~pay_data[0];
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (rst) begin
            beat_valid <= 1'b0;
            pay_first  <= 1'b0;
        end else begin
            beat_valid <= desc_valid;
            if (desc_valid) begin
                pay_first <= desc.first;
            end
        end
    end

    ////////////////////////////////////////
    // beat payload
    always_ff @(posedge clk_ifc) begin
        if (desc_valid) begin
            beat.first <= desc.first;
            beat.last  <= desc.last;
            if (desc.first) begin
                beat.data <= hdr_data;
                beat.keep <= '1;
                // seed in both halves
                lfsr      <= {2{desc.req.seed}};
            end else begin
                beat.data <= pay_data;
                beat.keep <= desc.keep;
                lfsr      <= lfsr_step;
            end
        end
    end

endmodule

// File: source/pkt_stream_checker.sv
////////////////////////////////////////
// stage 3, stream checker
// regenerates payload, one result each
////////////////////////////////////////

`timescale 1ns/10ps

`include "pkt_defines.svh"

module pkt_stream_checker (
    input  logic                        clk_ifc,
    input  logic                        rst,
    input  pkt_stream_pkg::beat_t       beat,
    input  logic                        beat_valid,
    output pkt_check_pkg::pkt_result_t  result,
    output logic                        result_valid
);

    logic [31:0]                              hdr_seed;
    logic [pkt_stream_pkg::LEN_W-1:0]         hdr_len;
    logic [pkt_stream_pkg::DATA_W-1:0]        lfsr;
    logic [pkt_stream_pkg::DATA_W-1:0]        lfsr_step;
    logic [pkt_stream_pkg::DATA_W-1:0]        exp_data;
    logic [pkt_stream_pkg::BEAT_CNT_W-1:0]    pay_cnt;
    logic [pkt_stream_pkg::BEAT_CNT_W-1:0]    exp_pay;
    logic [pkt_stream_pkg::LEN_W:0]           len_round;
    logic [pkt_check_pkg::BAD_CNT_W-1:0]      bad_cnt;
    logic [pkt_check_pkg::BAD_CNT_W-1:0]      beat_bad;
    logic [pkt_check_pkg::BAD_CNT_W:0]        bad_sum;
    logic [pkt_check_pkg::BAD_CNT_W-1:0]      bad_sat;

    ////////////////////////////////////////
    // expected data and byte compare
    always_comb begin
        lfsr_step = pkt_stream_pkg::lfsr_next(lfsr);
        exp_data  = lfsr_step & pkt_stream_pkg::keep_to_mask(beat.keep);
        beat_bad  = '0;
        for (int i = 0; i < `PKT_DATA_BYTES; i++) begin
            if (beat.data[i*8 +: 8] != exp_data[i*8 +: 8]) begin
                beat_bad = beat_bad + 1'b1;
            end
        end
        // running count, clamp instead of wrap
        bad_sum = {1'b0, bad_cnt} + {1'b0, beat_bad};
        bad_sat = bad_sum[pkt_check_pkg::BAD_CNT_W] ? '1 : bad_sum[pkt_check_pkg::BAD_CNT_W-1:0];
    end

    // payload beats implied by the header length
    assign len_round = {1'b0, hdr_len} + (pkt_stream_pkg::LEN_W + 1)'(`PKT_DATA_BYTES - 1);
    assign exp_pay   = pkt_stream_pkg::BEAT_CNT_W'(len_round >> pkt_stream_pkg::BYTE_IDX_W);

    ////////////////////////////////////////
    // packet tracking
    always_ff @(posedge clk_ifc) begin
        if (rst) begin
            pay_cnt      <= '0;
            bad_cnt      <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (beat_valid) begin
                if (beat.first) begin
                    pay_cnt      <= '0;
                    bad_cnt      <= '0;
                    // header with last set, a packet with no payload
                    result_valid <= beat.last;
                end else begin
                    pay_cnt      <= pay_cnt + 1'b1;
                    bad_cnt      <= bad_sat;
                    result_valid <= beat.last;
                end
            end
        end
    end

    // header fields, LFSR and result payload
    always_ff @(posedge clk_ifc) begin
        if (beat_valid && beat.first) begin
            hdr_seed <= beat.data[31:0];
            hdr_len  <= beat.data[39:32];
            lfsr     <= {2{beat.data[31:0]}};
            if (beat.last) begin
                result.seed         <= beat.data[31:0];
                result.byte_len     <= beat.data[39:32];
                result.data_error   <= 1'b0;
                result.length_error <= (beat.data[39:32] != '0);
                result.bad_bytes    <= '0;
            end
        end else if (beat_valid) begin
            lfsr <= lfsr_step;
            if (beat.last) begin
                result.seed         <= hdr_seed;
                result.byte_len     <= hdr_len;
                result.data_error   <= (bad_sat != '0);
                // this beat included in the count
                result.length_error <= ((pay_cnt + 1'b1) != exp_pay);
                result.bad_bytes    <= bad_sat;
            end
        end
    end

endmodule

// File: source/pkt_loop_top.sv
////////////////////////////////////////
// packet loopback top
// sequencer, generator, checker chain
////////////////////////////////////////

`timescale 1ns/10ps

module pkt_loop_top (
    input  logic                       clk_ifc,
    input  logic                       rst,
    input  logic                       send_req,
    input  logic [31:0]                seed,
    input  logic [7:0]                 byte_len,
    input  logic                       corrupt,
    output logic                       busy,
    output logic                       beat_valid,
    output logic                       beat_last,
    output pkt_check_pkg::pkt_result_t result,
    output logic                       result_valid
);

    pkt_stream_pkg::beat_desc_t desc;
    logic                       desc_valid;
    pkt_stream_pkg::beat_t      beat;

    // beat tap for the bench
    assign beat_last = beat.last;

    pkt_beat_sequencer u_seq (
        .clk_ifc    (clk_ifc),
        .rst        (rst),
        .send_req   (send_req),
        .seed       (seed),
        .byte_len   (byte_len),
        .corrupt    (corrupt),
        .busy       (busy),
        .desc       (desc),
        .desc_valid (desc_valid)
    );

    pkt_payload_gen u_gen (
        .clk_ifc    (clk_ifc),
        .rst        (rst),
        .desc       (desc),
        .desc_valid (desc_valid),
        .beat       (beat),
        .beat_valid (beat_valid)
    );

    pkt_stream_checker u_chk (
        .clk_ifc      (clk_ifc),
        .rst          (rst),
        .beat         (beat),
        .beat_valid   (beat_valid),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// File: bench/pkt_loop_sva.sv
////////////////////////////////////////
// stream and busy assertions, bound to top
////////////////////////////////////////

`timescale 1ns/10ps

module pkt_loop_sva (
    input logic clk_ifc,
    input logic rst,
    input logic send_req,
    input logic busy,
    input logic beat_valid,
    input logic beat_last,
    input logic result_valid
);

    // busy only rises after a request
    assert property (@(posedge clk_ifc) disable iff (rst)
        $rose(busy) |-> $past(send_req))
        else $error("busy rose without an accepted request");

    // no holes between first and last beat
    assert property (@(posedge clk_ifc) disable iff (rst)
        beat_valid && !beat_last |=> beat_valid)
        else $error("gap in beat_valid inside a packet");

    // result one cycle behind the last beat
    assert property (@(posedge clk_ifc) disable iff (rst)
        result_valid |-> $past(beat_valid && beat_last))
        else $error("result_valid without a last beat one cycle before");

    // results are single-cycle pulses
    assert property (@(posedge clk_ifc) disable iff (rst)
        result_valid |=> !result_valid)
        else $error("result_valid held longer than one cycle");

endmodule

bind pkt_loop_top pkt_loop_sva u_sva (
    .clk_ifc      (clk_ifc),
    .rst          (rst),
    .send_req     (send_req),
    .busy         (busy),
    .beat_valid   (beat_valid),
    .beat_last    (beat_last),
    .result_valid (result_valid)
);

// File: bench/pkt_loop_tb.sv
////////////////////////////////////////
// packet loopback testbench
// pattern-driven requests, result checks
////////////////////////////////////////

`timescale 1ns/10ps

`include "pkt_defines.svh"

module pkt_loop_tb;

    localparam int NUM_PAT    = 13;
    localparam int WAIT_LIMIT = 200;

    // one pending packet, pushed at accept
    typedef struct packed {
        logic [31:0] seed;
        logic [7:0]  byte_len;
        logic        corrupt;
        logic [7:0]  beats;
        logic [3:0]  bad_bytes;
        logic [31:0] accept_cyc;
    } exp_pkt_t;

    logic                       clk_ifc;
    logic                       rst;
    logic                       send_req;
    logic [31:0]                seed;
    logic [7:0]                 byte_len;
    logic                       corrupt;
    logic                       busy;
    logic                       beat_valid;
    logic                       beat_last;
    pkt_check_pkg::pkt_result_t result;
    logic                       result_valid;

    // packed line: seed, length, corrupt nibble, beats, bad bytes
    logic [55:0] pat_mem [0:NUM_PAT-1];
    logic [31:0] pat_seed;
    logic [7:0]  pat_len;
    logic [3:0]  pat_cor;
    logic [7:0]  pat_beats;
    logic [3:0]  pat_bad;

    exp_pkt_t    res_q[$];
    logic [7:0]  beat_q[$];
    exp_pkt_t    front;
    int          cyc;
    int          beat_cnt;
    int          res_cnt;

    pkt_loop_top u_dut (
        .clk_ifc      (clk_ifc),
        .rst          (rst),
        .send_req     (send_req),
        .seed         (seed),
        .byte_len     (byte_len),
        .corrupt      (corrupt),
        .busy         (busy),
        .beat_valid   (beat_valid),
        .beat_last    (beat_last),
        .result       (result),
        .result_valid (result_valid)
    );

    // 4 ns period
    always #2 clk_ifc = ~clk_ifc;

    task automatic report_and_stop(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            report_and_stop($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // polls on falling edges, bounded
    task automatic wait_for_busy(input logic level);
        int n;
        n = 0;
        while (busy !== level) begin
            @(negedge clk_ifc);
            n++;
            assert (n <= WAIT_LIMIT) else begin
                report_and_stop($sformatf("timeout waiting for busy to become %0d", level));
            end
        end
    endtask

    ////////////////////////////////////////
    // monitor, sees values from before each edge
    always @(posedge clk_ifc) begin
        cyc = cyc + 1;
        if (!rst) begin
            // accept condition as the sequencer sees it
            if (send_req && !busy && byte_len != 8'd0) begin
                res_q.push_back(exp_pkt_t'{seed, byte_len, corrupt, pat_beats, pat_bad,
                                           32'(cyc)});
                beat_q.push_back(pat_beats);
            end
            if (beat_valid) begin
                beat_cnt = beat_cnt + 1;
                if (beat_last) begin
                    assert (beat_q.size() > 0) else begin
                        report_and_stop("last beat seen with no packet in flight");
                    end
                    check_field("beat count", 32'(beat_cnt), 32'(beat_q.pop_front()));
                    beat_cnt = 0;
                end
            end
            if (result_valid) begin
                assert (res_q.size() > 0) else begin
                    report_and_stop("result pulse seen with no pending request");
                end
                front = res_q.pop_front();
                check_field("result.seed", result.seed, front.seed);
                check_field("result.byte_len", 32'(result.byte_len), 32'(front.byte_len));
                check_field("result.data_error", 32'(result.data_error), 32'(front.corrupt));
                check_field("result.length_error", 32'(result.length_error), 32'd0);
                check_field("result.bad_bytes", 32'(result.bad_bytes), 32'(front.bad_bytes));
                // rise edge is the one before this sample
                check_field("result_valid latency", 32'(cyc - 1) - front.accept_cyc,
                            32'(front.beats) + 32'd3);
                res_cnt = res_cnt + 1;
            end
        end
    end

    ////////////////////////////////////////
    // stimulus
    initial begin
        int rule_beats;
        int n;
        clk_ifc   = 1'b0;
        rst       = 1'b1;
        send_req  = 1'b0;
        seed      = '0;
        byte_len  = '0;
        corrupt   = 1'b0;
        pat_seed  = '0;
        pat_len   = '0;
        pat_cor   = '0;
        pat_beats = '0;
        pat_bad   = '0;
        cyc       = 0;
        beat_cnt  = 0;
        res_cnt   = 0;
        $readmemh("bench/pkt_patterns.txt", pat_mem);

        repeat (4) @(posedge clk_ifc);
        @(negedge clk_ifc);
        rst = 1'b0;
        // quiet outputs before any request
        repeat (3) begin
            @(negedge clk_ifc);
            check_field("busy", 32'(busy), 32'd0);
            check_field("beat_valid", 32'(beat_valid), 32'd0);
            check_field("result_valid", 32'(result_valid), 32'd0);
        end

        for (int p = 0; p < NUM_PAT; p++) begin
            {pat_seed, pat_len, pat_cor, pat_beats, pat_bad} = pat_mem[p];
            // header plus payload beats rounded up
            rule_beats = 1 + (int'(pat_len) + `PKT_DATA_BYTES - 1) / `PKT_DATA_BYTES;
            check_field("pattern beats", 32'(pat_beats), 32'(rule_beats));
            seed     = pat_seed;
            byte_len = pat_len;
            corrupt  = pat_cor[0];
            send_req = 1'b1;
            wait_for_busy(1'b1);
            send_req = 1'b0;
            wait_for_busy(1'b0);
        end

        // last result still in flight
        n = 0;
        while (res_cnt < NUM_PAT) begin
            @(negedge clk_ifc);
            n++;
            assert (n <= WAIT_LIMIT) else begin
                report_and_stop("timeout waiting for the remaining results");
            end
        end
        repeat (4) @(negedge clk_ifc);

        if (res_cnt == NUM_PAT && res_q.size() == 0 && beat_q.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            report_and_stop($sformatf("got %0d results for %0d requests", res_cnt, NUM_PAT));
        end
    end

endmodule

// File: bench/pkt_patterns.txt
// hex digits per line: seed(8) byte_len(2) corrupt(1) beats(2) bad_bytes(1)
// beats counts the header, bad_bytes is the expected checker count
12345678010020
deadbeef080020
0badf00d090030
a5a5a5a5ff0210
00000001101031
ffffffff070020
13579bdf011021
2468ace0400090
cafef00d4110a1
00000000030020
7f7f7f7ffe1211
89abcdef110040
e5d9f0ae800110

// File: list.f
+incdir+source
source/pkt_stream_pkg.sv
source/pkt_check_pkg.sv
source/pkt_beat_sequencer.sv
source/pkt_payload_gen.sv
source/pkt_stream_checker.sv
source/pkt_loop_top.sv
bench/pkt_loop_sva.sv
bench/pkt_loop_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the packet loopback testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module pkt_loop_tb -Mdir obj_dir -f list.f

status=0
./obj_dir/Vpkt_loop_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation passed"
